/* vlog.f */
+incdir+design
design/usb_rx_pkg.sv
design/usb_line_decoder.sv
design/usb_byte_assembler.sv
design/usb_packet_controller.sv
design/usb_rx_fifo_apb.sv
design/usb_rx.sv
verif/tb_clk_gen.sv
verif/tb_usb_rx.sv

/* run_sim.sh */
#!/bin/sh
# build and run the usb receive testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_usb_rx \
    -Mdir obj_dir -o sim_usb_rx
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_usb_rx)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

/* verif/tb_usb_rx.sv */
`timescale 1ns/10ps
`include "usb_rx_config.svh"

module tb_usb_rx;
    localparam int NUM_PACKETS = 40;
    localparam int CYCLES_PER_PACKET = 1500;
    localparam int MAX_CYCLES = NUM_PACKETS * CYCLES_PER_PACKET;
    localparam usb_rx_pkg::apb_addr_t REG_DATA = usb_rx_pkg::apb_addr_t'(`USB_RX_REG_DATA);
    localparam usb_rx_pkg::apb_addr_t REG_STATUS = usb_rx_pkg::apb_addr_t'(`USB_RX_REG_STATUS);

    logic tb_clk;
    logic tb_n_rst;
    logic d_plus;
    logic d_minus;
    usb_rx_pkg::rx_packet_t rx_packet;
    logic packet_done;
    logic r_error;
    logic psel;
    logic penable;
    logic pwrite;
    usb_rx_pkg::apb_addr_t paddr;
    usb_rx_pkg::apb_data_t pwdata;
    usb_rx_pkg::apb_data_t prdata;
    logic pready;
    logic pslverr;

    logic [31:0] lfsr;
    logic tx_bits[$];
    logic [7:0] exp_fifo[$];
    usb_rx_pkg::rx_packet_t exp_code;
    logic exp_done;
    logic exp_err;
    int pkt_idx;
    int cycle_cnt = 0;
    int checks;
    int errors;

    tb_clk_gen tb_clk_gen_inst (.tb_clk(tb_clk));

    usb_rx usb_rx_inst (
        .tb_clk      (tb_clk),
        .tb_n_rst    (tb_n_rst),
        .d_plus      (d_plus),
        .d_minus     (d_minus),
        .rx_packet   (rx_packet),
        .packet_done (packet_done),
        .r_error     (r_error),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    always @(posedge tb_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: no end of test after %0d cycles, packet %0d", cycle_cnt, pkt_idx);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    // one byte in four is all ones so stuffing gets exercised
    task automatic rand_byte(output logic [7:0] b);
        logic [31:0] r;
        rand_bits(10, r);
        b = (r[9:8] == 2'b00) ? 8'hFF : r[7:0];
    endtask

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at time %0t: packet %0d %s is %0h, expected %0h",
                     $time, pkt_idx, what, got, want);
        end
    endtask

    // ******************************
    // line encoder
    // ******************************
    task automatic queue_byte(input logic [7:0] b, input int nbits);
        for (int i = 0; i < nbits; i++) begin
            tx_bits.push_back(b[i]);
        end
    endtask

    task automatic line_state(input logic dp, input logic dm);
        @(posedge tb_clk);
        d_plus <= dp;
        d_minus <= dm;
        repeat (`USB_RX_CLKS_PER_BIT - 1) @(posedge tb_clk);
    endtask

    // nrzi from idle J, then se0 for two bits and two bits of J
    task automatic send_packet();
        logic lvl;
        int ones;
        lvl = 1'b1;
        ones = 0;
        foreach (tx_bits[i]) begin
            if (!tx_bits[i]) begin
                lvl = !lvl;
            end
            line_state(lvl, !lvl);
            ones = tx_bits[i] ? ones + 1 : 0;
            if (ones == `USB_RX_STUFF_RUN) begin
                lvl = !lvl;
                line_state(lvl, !lvl);
                ones = 0;
            end
        end
        repeat (2) line_state(1'b0, 1'b0);
        repeat (2) line_state(1'b1, 1'b0);
        tx_bits.delete();
    endtask

    // ******************************
    // packet builder and model
    // ******************************
    task automatic build_packet(input int idx);
        logic [31:0] r;
        logic [7:0] b;
        logic [6:0] addr;
        logic [3:0] endp;
        int kind;
        int n;
        rand_bits(4, r);
        kind = (idx < 9) ? idx : int'(r % 9);
        exp_code = usb_rx_pkg::PKT_NONE;
        exp_done = 1'b0;
        exp_err = 1'b0;
        if (kind == 7) begin
            rand_bits(8, r);
            // first bit stays zero so the packet still opens with a K
            b = (r[7:1] == 7'h40) ? 8'h82 : {r[7:1], 1'b0};
        end else begin
            b = `USB_RX_SYNC_BYTE;
        end
        queue_byte(b, 8);
        case (kind)
            0: begin
                queue_byte(8'hC3, 8);
                rand_bits(3, r);
                n = int'(r % 6) + 1;
                // payload then two crc bytes
                for (int i = 0; i < n + 2; i++) begin
                    rand_byte(b);
                    queue_byte(b, 8);
                    if (i < n) begin
                        exp_fifo.push_back(b);
                    end
                end
                exp_code = usb_rx_pkg::PKT_DATA;
                exp_done = 1'b1;
            end
            1, 2: begin
                queue_byte((kind == 1) ? 8'h69 : 8'hE1, 8);
                rand_bits(20, r);
                addr = r[0] ? `USB_RX_DEV_ADDR : r[7:1];
                endp = r[0] ? `USB_RX_DEV_ENDP : r[11:8];
                queue_byte({endp[0], addr}, 8);
                queue_byte({r[16:12], endp[3:1]}, 8);
                exp_code = (kind == 1) ? usb_rx_pkg::PKT_IN : usb_rx_pkg::PKT_OUT;
                exp_done = (addr == `USB_RX_DEV_ADDR) && (endp == `USB_RX_DEV_ENDP);
            end
            3: begin
                queue_byte(8'hD2, 8);
                exp_code = usb_rx_pkg::PKT_ACK;
            end
            4: begin
                queue_byte(8'h5A, 8);
                exp_code = usb_rx_pkg::PKT_NAK;
            end
            5: begin
                rand_bits(4, r);
                while (r[3:0] inside {4'h6, 4'hE, 4'hC, 4'hD, 4'h5}) begin
                    rand_bits(4, r);
                end
                queue_byte({r[3:0], ~r[3:0]}, 8);
                exp_code = usb_rx_pkg::PKT_UNSUP;
            end
            6: begin
                rand_bits(8, r);
                if (r[3:0] == ~r[7:4]) begin
                    r[0] = !r[0];
                end
                queue_byte(r[7:0], 8);
                exp_err = 1'b1;
            end
            7: begin
                queue_byte(8'hC3, 8);
                rand_byte(b);
                queue_byte(b, 8);
                exp_err = 1'b1;
            end
            default: begin
                // data cut off inside a byte
                queue_byte(8'hC3, 8);
                rand_bits(3, r);
                n = int'(r % 6);
                for (int i = 0; i < n; i++) begin
                    rand_byte(b);
                    queue_byte(b, 8);
                    if (i < n - 2) begin
                        exp_fifo.push_back(b);
                    end
                end
                rand_bits(3, r);
                rand_byte(b);
                queue_byte(b, (r[2:0] == 3'd0) ? 1 : int'(r[2:0]));
                exp_code = usb_rx_pkg::PKT_DATA;
                exp_err = 1'b1;
            end
        endcase
    endtask

    // ******************************
    // apb host side
    // ******************************
    task automatic apb_xfer(input logic write, input usb_rx_pkg::apb_addr_t addr,
                            input usb_rx_pkg::apb_data_t wdata,
                            output usb_rx_pkg::apb_data_t rdata, output logic err);
        @(posedge tb_clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge tb_clk);
        penable <= 1'b1;
        @(negedge tb_clk);
        rdata = prdata;
        err = pslverr;
        expect_equal("pready", 32'(pready), 32'd1);
        @(posedge tb_clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic drain_and_check();
        usb_rx_pkg::apb_data_t data;
        logic err;
        logic [31:0] r;
        apb_xfer(1'b0, REG_STATUS, '0, data, err);
        expect_equal("fifo count", 32'(data[3:0]), 32'(exp_fifo.size()));
        expect_equal("status pslverr", 32'(err), 32'd0);
        // no packet pushes more than the fifo holds
        expect_equal("overflow after packet", 32'(data[6]), 32'd0);
        while (!data[4]) begin
            apb_xfer(1'b0, REG_DATA, '0, data, err);
            if (exp_fifo.size() == 0) begin
                errors++;
                $display("FIFO returned byte %0h in packet %0d that was never pushed",
                         data[7:0], pkt_idx);
            end else begin
                expect_equal("fifo byte", data, 32'(exp_fifo.pop_front()));
            end
            apb_xfer(1'b0, REG_STATUS, '0, data, err);
        end
        if (exp_fifo.size() != 0) begin
            errors++;
            $display("FIFO went empty with %0d bytes of packet %0d missing",
                     exp_fifo.size(), pkt_idx);
            exp_fifo.delete();
        end
        expect_equal("final count", 32'(data[3:0]), 32'd0);
        expect_equal("overflow flag", 32'(data[6]), 32'd0);
        // error responses
        apb_xfer(1'b0, REG_DATA, '0, data, err);
        expect_equal("empty read data", data, 32'd0);
        expect_equal("empty read pslverr", 32'(err), 32'd1);
        rand_bits(32, r);
        apb_xfer(1'b1, REG_DATA, r, data, err);
        expect_equal("write pslverr", 32'(err), 32'd1);
        apb_xfer(1'b0, 4'h8, '0, data, err);
        expect_equal("unmapped pslverr", 32'(err), 32'd1);
    endtask

    initial begin
        lfsr = 32'h5e6c;
        checks = 0;
        errors = 0;
        pkt_idx = 0;
        tb_n_rst <= 1'b0;
        d_plus <= 1'b1;
        d_minus <= 1'b0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        repeat (3) @(posedge tb_clk);
        tb_n_rst <= 1'b1;
        repeat (4) @(posedge tb_clk);
        for (int p = 0; p < NUM_PACKETS; p++) begin
            pkt_idx = p;
            build_packet(p);
            send_packet();
            @(negedge tb_clk);
            while (rx_packet == usb_rx_pkg::PKT_NONE && !r_error && !packet_done) begin
                @(negedge tb_clk);
            end
            expect_equal("rx_packet", 32'(rx_packet), 32'(exp_code));
            expect_equal("packet_done", 32'(packet_done), 32'(exp_done));
            expect_equal("r_error", 32'(r_error), 32'(exp_err));
            drain_and_check();
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic tb_clk
);
    // 100 ns period
    localparam int HALF_PERIOD = 50;

    initial begin
        tb_clk = 1'b0;
        forever begin
            #HALF_PERIOD tb_clk = !tb_clk;
        end
    end

endmodule

/* design/usb_rx.sv */
`timescale 1ns/10ps

module usb_rx (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic d_plus,
    input  logic d_minus,
    output usb_rx_pkg::rx_packet_t rx_packet,
    output logic packet_done,
    output logic r_error,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  usb_rx_pkg::apb_addr_t paddr,
    input  usb_rx_pkg::apb_data_t pwdata,
    output usb_rx_pkg::apb_data_t prdata,
    output logic pready,
    output logic pslverr
);
    logic bit_valid;
    logic bit_data;
    logic sop;
    logic eop;
    logic byte_valid;
    usb_rx_pkg::usb_byte_t byte_data;
    logic partial;
    logic push;
    usb_rx_pkg::usb_byte_t push_data;

    // line side
    usb_line_decoder usb_line_decoder_inst (
        .tb_clk    (tb_clk),
        .tb_n_rst  (tb_n_rst),
        .d_plus    (d_plus),
        .d_minus   (d_minus),
        .bit_valid (bit_valid),
        .bit_data  (bit_data),
        .sop       (sop),
        .eop       (eop)
    );

    usb_byte_assembler usb_byte_assembler_inst (
        .tb_clk     (tb_clk),
        .tb_n_rst   (tb_n_rst),
        .bit_valid  (bit_valid),
        .bit_data   (bit_data),
        .sop        (sop),
        .eop        (eop),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .partial    (partial)
    );

    usb_packet_controller usb_packet_controller_inst (
        .tb_clk      (tb_clk),
        .tb_n_rst    (tb_n_rst),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .partial     (partial),
        .sop         (sop),
        .eop         (eop),
        .rx_packet   (rx_packet),
        .packet_done (packet_done),
        .r_error     (r_error),
        .push        (push),
        .push_data   (push_data)
    );

    // host side
    usb_rx_fifo_apb usb_rx_fifo_apb_inst (
        .tb_clk    (tb_clk),
        .tb_n_rst  (tb_n_rst),
        .push      (push),
        .push_data (push_data),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

endmodule

/* design/usb_rx_fifo_apb.sv */
`timescale 1ns/10ps
`include "usb_rx_config.svh"

module usb_rx_fifo_apb (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic push,
    input  usb_rx_pkg::usb_byte_t push_data,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  usb_rx_pkg::apb_addr_t paddr,
    input  usb_rx_pkg::apb_data_t pwdata,
    output usb_rx_pkg::apb_data_t prdata,
    output logic pready,
    output logic pslverr
);
    localparam int PTR_W = $clog2(`USB_RX_FIFO_DEPTH);

    usb_rx_pkg::usb_byte_t mem [`USB_RX_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    usb_rx_pkg::fifo_count_t count;
    logic overflow;
    logic empty;
    logic full;
    logic access;
    logic sel_data;
    logic sel_status;
    logic wr_ok;
    logic rd_ok;

    assign empty = count == '0;
    assign full = count == usb_rx_pkg::fifo_count_t'(`USB_RX_FIFO_DEPTH);
    assign access = psel && penable;
    assign sel_data = paddr == usb_rx_pkg::apb_addr_t'(`USB_RX_REG_DATA);
    assign sel_status = paddr == usb_rx_pkg::apb_addr_t'(`USB_RX_REG_STATUS);
    assign wr_ok = push && !full;
    assign rd_ok = access && !pwrite && sel_data && !empty;

    // zero wait states
    assign pready = 1'b1;
    assign pslverr = access && (pwrite || !(sel_data || sel_status) || (sel_data && empty));

    // ******************************
    // apb read mux
    // ******************************
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            if (sel_data && !empty) begin
                prdata[`USB_RX_BYTE_W-1:0] = mem[rd_ptr];
            end else if (sel_status) begin
                prdata[6:0] = {overflow, full, empty, count};
            end
        end
    end

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + usb_rx_pkg::fifo_count_t'(wr_ok)
                           - usb_rx_pkg::fifo_count_t'(rd_ok);
            // sticky until status is read, a new drop wins
            if (push && full) begin
                overflow <= 1'b1;
            end else if (access && !pwrite && sel_status) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge tb_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_count_bound: assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        count <= usb_rx_pkg::fifo_count_t'(`USB_RX_FIFO_DEPTH));

    // master holds the transfer steady from setup into access
    a_apb_stable: assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        access |-> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

/* design/usb_packet_controller.sv */
`timescale 1ns/10ps
`include "usb_rx_config.svh"

module usb_packet_controller (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic byte_valid,
    input  usb_rx_pkg::usb_byte_t byte_data,
    input  logic partial,
    input  logic sop,
    input  logic eop,
    output usb_rx_pkg::rx_packet_t rx_packet,
    output logic packet_done,
    output logic r_error,
    output logic push,
    output usb_rx_pkg::usb_byte_t push_data
);
    localparam int HOLD = `USB_RX_CRC_BYTES;
    localparam int HOLD_W = $clog2(HOLD + 1);

    usb_rx_pkg::ctrl_state_t state;
    usb_rx_pkg::rx_packet_t code_q;
    logic err_q;
    logic done_q;
    logic [HOLD_W-1:0] hold_cnt;
    usb_rx_pkg::usb_byte_t hold [HOLD];
    usb_rx_pkg::usb_byte_t tok_lo;
    logic pid_ok;
    logic tok_match;
    logic data_err;

    function automatic usb_rx_pkg::rx_packet_t decode_pid(input usb_rx_pkg::usb_byte_t pid);
        usb_rx_pkg::rx_packet_t code;
        case (pid)
            8'h69: code = usb_rx_pkg::PKT_IN;
            8'hE1: code = usb_rx_pkg::PKT_OUT;
            8'hC3: code = usb_rx_pkg::PKT_DATA;
            8'hD2: code = usb_rx_pkg::PKT_ACK;
            8'h5A: code = usb_rx_pkg::PKT_NAK;
            default: code = usb_rx_pkg::PKT_UNSUP;
        endcase
        return code;
    endfunction

    // check nibble is the complement of the pid nibble
    assign pid_ok = byte_data[3:0] == ~byte_data[7:4];
    // endpoint straddles the two token bytes
    assign tok_match = (tok_lo[6:0] == `USB_RX_DEV_ADDR) &&
                       ({byte_data[2:0], tok_lo[7]} == `USB_RX_DEV_ENDP);
    assign data_err = partial || (hold_cnt != HOLD_W'(HOLD));

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            state <= usb_rx_pkg::IDLE;
            code_q <= usb_rx_pkg::PKT_NONE;
            err_q <= 1'b0;
            done_q <= 1'b0;
            hold_cnt <= '0;
            push <= 1'b0;
            rx_packet <= usb_rx_pkg::PKT_NONE;
            packet_done <= 1'b0;
            r_error <= 1'b0;
        end else begin
            push <= 1'b0;
            if (sop) begin
                state <= usb_rx_pkg::SYNC;
                code_q <= usb_rx_pkg::PKT_NONE;
                err_q <= 1'b0;
                done_q <= 1'b0;
                hold_cnt <= '0;
                rx_packet <= usb_rx_pkg::PKT_NONE;
                packet_done <= 1'b0;
                r_error <= 1'b0;
            end else if (eop && state != usb_rx_pkg::IDLE && state != usb_rx_pkg::DONE) begin
                // ******************************
                // report on end of packet
                // ******************************
                state <= usb_rx_pkg::DONE;
                rx_packet <= code_q;
                case (state)
                    usb_rx_pkg::PAYLOAD: begin
                        r_error <= data_err;
                        packet_done <= !data_err;
                    end
                    usb_rx_pkg::DISCARD: begin
                        r_error <= err_q;
                        packet_done <= done_q;
                    end
                    // packet cut short before it was complete
                    default: begin
                        r_error <= 1'b1;
                        packet_done <= 1'b0;
                    end
                endcase
            end else if (byte_valid) begin
                case (state)
                    usb_rx_pkg::SYNC: begin
                        if (byte_data == `USB_RX_SYNC_BYTE) begin
                            state <= usb_rx_pkg::PID;
                        end else begin
                            err_q <= 1'b1;
                            state <= usb_rx_pkg::DISCARD;
                        end
                    end
                    usb_rx_pkg::PID: begin
                        if (!pid_ok) begin
                            err_q <= 1'b1;
                            state <= usb_rx_pkg::DISCARD;
                        end else begin
                            code_q <= decode_pid(byte_data);
                            case (decode_pid(byte_data))
                                usb_rx_pkg::PKT_IN,
                                usb_rx_pkg::PKT_OUT: state <= usb_rx_pkg::TOKEN1;
                                usb_rx_pkg::PKT_DATA: state <= usb_rx_pkg::PAYLOAD;
                                default: state <= usb_rx_pkg::DISCARD;
                            endcase
                        end
                    end
                    usb_rx_pkg::TOKEN1: state <= usb_rx_pkg::TOKEN2;
                    usb_rx_pkg::TOKEN2: begin
                        done_q <= tok_match;
                        state <= usb_rx_pkg::DISCARD;
                    end
                    usb_rx_pkg::PAYLOAD: begin
                        // oldest held byte leaves once the hold-back is full
                        if (hold_cnt == HOLD_W'(HOLD)) begin
                            push <= 1'b1;
                        end else begin
                            hold_cnt <= hold_cnt + 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // hold-back line and token low byte
    always_ff @(posedge tb_clk) begin
        if (byte_valid && state == usb_rx_pkg::PAYLOAD) begin
            push_data <= hold[0];
            for (int i = 0; i < HOLD - 1; i++) begin
                hold[i] <= hold[i+1];
            end
            hold[HOLD-1] <= byte_data;
        end
        if (byte_valid && state == usb_rx_pkg::TOKEN1) begin
            tok_lo <= byte_data;
        end
    end

    // a push always comes from a payload byte of the same packet
    a_push_in_payload: assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        push |-> state == usb_rx_pkg::PAYLOAD && !sop && !eop);

endmodule

/* design/usb_byte_assembler.sv */
`timescale 1ns/10ps
`include "usb_rx_config.svh"

module usb_byte_assembler (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic bit_valid,
    input  logic bit_data,
    input  logic sop,
    input  logic eop,
    output logic byte_valid,
    output usb_rx_pkg::usb_byte_t byte_data,
    output logic partial
);
    localparam int CNT_W = $clog2(`USB_RX_BYTE_W);

    logic [CNT_W-1:0] bit_cnt;

    assign partial = bit_cnt != '0;

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            bit_cnt <= '0;
            byte_valid <= 1'b0;
        end else if (sop || eop) begin
            bit_cnt <= '0;
            byte_valid <= 1'b0;
        end else begin
            // last bit of the byte completes it
            byte_valid <= bit_valid && (bit_cnt == '1);
            if (bit_valid) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge tb_clk) begin
        if (bit_valid) begin
            byte_data <= {bit_data, byte_data[`USB_RX_BYTE_W-1:1]};
        end
    end

endmodule

/* design/usb_line_decoder.sv */
`timescale 1ns/10ps
`include "usb_rx_config.svh"

module usb_line_decoder (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic d_plus,
    input  logic d_minus,
    output logic bit_valid,
    output logic bit_data,
    output logic sop,
    output logic eop
);
    localparam int PHASE_W = $clog2(`USB_RX_CLKS_PER_BIT);
    localparam int ONES_W = $clog2(`USB_RX_STUFF_RUN + 1);
    localparam int SE0_W = $clog2(`USB_RX_CLKS_PER_BIT + 1);

    logic [1:0] dp_sync;
    logic [1:0] dm_sync;
    logic dp_prev;
    // line level at the previous bit sample
    logic last_dp;
    logic active;
    logic [PHASE_W-1:0] phase;
    logic [ONES_W-1:0] ones;
    logic [SE0_W-1:0] se0_cnt;
    logic dp;
    logic dm;
    logic line_edge;
    logic se0;
    logic j_state;
    logic sample;
    logic sop_cond;
    logic eop_cond;
    logic nrzi_bit;

    assign dp = dp_sync[1];
    assign dm = dm_sync[1];
    assign line_edge = dp != dp_prev;
    assign se0 = !dp && !dm;
    assign j_state = dp && !dm;

    // idle is J, first K starts a packet
    assign sop_cond = !active && line_edge && !se0;
    assign eop_cond = active && j_state && (se0_cnt == SE0_W'(`USB_RX_CLKS_PER_BIT));
    // mid-bit sample, half a bit after the last transition
    assign sample = active && !se0 && !eop_cond &&
                    (phase == PHASE_W'(`USB_RX_CLKS_PER_BIT / 2));
    // nrzi: no change means 1
    assign nrzi_bit = dp == last_dp;

    // ******************************
    // synchronizer and bit clock
    // ******************************
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            dp_sync <= 2'b11;
            dm_sync <= 2'b00;
            dp_prev <= 1'b1;
            phase <= '0;
            se0_cnt <= '0;
        end else begin
            dp_sync <= {dp_sync[0], d_plus};
            dm_sync <= {dm_sync[0], d_minus};
            dp_prev <= dp;
            // restart the phase on every transition
            if (line_edge) begin
                phase <= PHASE_W'(1);
            end else begin
                phase <= phase + 1'b1;
            end
            if (!se0) begin
                se0_cnt <= '0;
            end else if (se0_cnt != SE0_W'(`USB_RX_CLKS_PER_BIT)) begin
                se0_cnt <= se0_cnt + 1'b1;
            end
        end
    end

    // ******************************
    // nrzi, unstuffing, framing
    // ******************************
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            active <= 1'b0;
            last_dp <= 1'b1;
            ones <= '0;
            bit_valid <= 1'b0;
            sop <= 1'b0;
            eop <= 1'b0;
        end else begin
            sop <= sop_cond;
            eop <= eop_cond;
            bit_valid <= 1'b0;
            if (sop_cond) begin
                active <= 1'b1;
                ones <= '0;
            end else if (eop_cond) begin
                active <= 1'b0;
                last_dp <= 1'b1;
            end else if (sample) begin
                last_dp <= dp;
                if (ones == ONES_W'(`USB_RX_STUFF_RUN)) begin
                    // stuffed zero, drop it
                    ones <= '0;
                end else begin
                    bit_valid <= 1'b1;
                    ones <= nrzi_bit ? ones + 1'b1 : '0;
                end
            end
        end
    end

    always_ff @(posedge tb_clk) begin
        if (sample) begin
            bit_data <= nrzi_bit;
        end
    end

    // eop only follows a stretch of se0, never a kept bit
    a_bit_eop_excl: assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        eop |-> !bit_valid && !$past(bit_valid));

endmodule

/* design/usb_rx_pkg.sv */
`include "usb_rx_config.svh"

package usb_rx_pkg;

    typedef logic [`USB_RX_BYTE_W-1:0] usb_byte_t;
    // one spare bit so a full fifo fits
    typedef logic [$clog2(`USB_RX_FIFO_DEPTH):0] fifo_count_t;
    typedef logic [`USB_RX_APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // packet codes reported on rx_packet
    typedef enum logic [2:0] {
        PKT_NONE  = 3'd0,
        PKT_IN    = 3'd1,
        PKT_OUT   = 3'd2,
        PKT_DATA  = 3'd3,
        PKT_ACK   = 3'd4,
        PKT_NAK   = 3'd5,
        PKT_UNSUP = 3'd6
    } rx_packet_t;

    typedef enum logic [2:0] {
        IDLE,
        SYNC,
        PID,
        TOKEN1,
        TOKEN2,
        PAYLOAD,
        DISCARD,
        DONE
    } ctrl_state_t;

endpackage

/* design/usb_rx_config.svh */
`ifndef USB_RX_CONFIG_SVH
`define USB_RX_CONFIG_SVH

// ******************************
// line and byte framing
// ******************************
`define USB_RX_BYTE_W 8
`define USB_RX_CLKS_PER_BIT 8
`define USB_RX_STUFF_RUN 6
// sync pattern KJKJKJKK, arrives lsb first
`define USB_RX_SYNC_BYTE 8'h80

// device identity for token match
`define USB_RX_DEV_ADDR 7'h70
`define USB_RX_DEV_ENDP 4'h4
`define USB_RX_CRC_BYTES 2

// ******************************
// receive fifo and apb map
// ******************************
`define USB_RX_FIFO_DEPTH 8
`define USB_RX_APB_ADDR_W 4
`define USB_RX_REG_DATA 0
`define USB_RX_REG_STATUS 4

`endif
